//--- noc_stat.f
logic/noc_stat_pkg.sv
logic/port_event_counter.sv
logic/router_stat_total.sv
logic/stat_wb_slave.sv
logic/noc_stat_top.sv
dv/noc_stat_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the NoC statistics testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -j 0 \
	--top-module noc_stat_tb -o noc_stat_sim \
	-f noc_stat.f > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/noc_stat_sim > sim.log 2>&1 \
	|| echo "simulator returned an error status"

cat sim.log

grep -qx "All checks passed" sim.log && echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }

//--- dv/noc_stat_tb.sv
// NoC statistics testbench
`timescale 1ns/1ps
`default_nettype none

module noc_stat_tb;
	import noc_stat_pkg::*;

	localparam int ACK_TIMEOUT = 20; // cycles

	logic clk = 1'b0;
	logic rst_n;
	logic [EV_W-1:0] flit_wr_i;
	logic [EV_W-1:0] pck_wr_i;
	logic [EV_W-1:0] flit_wr_o;
	logic [EV_W-1:0] pck_wr_o;
	logic [EV_W-1:0] flit_in_bypassed;
	logic [BYP_BUS_W-1:0] bypassed_num;
	logic cyc;
	logic stb;
	logic we;
	wb_adr_t adr;
	wb_dat_t dat_w;
	wb_dat_t dat_r;
	logic ack;

	cnt_t m_port [NR][MAX_P][NUM_STAT]; // reference counters
	cnt_t m_tot [NR][NUM_STAT];
	logic m_freeze;
	int checks;
	int errors;
	int timeouts;
	int unsigned seed_ret;

	noc_stat_top u_noc_stat_top (
		.clk              (clk),
		.rst_n            (rst_n),
		.flit_wr_i        (flit_wr_i),
		.pck_wr_i         (pck_wr_i),
		.flit_wr_o        (flit_wr_o),
		.pck_wr_o         (pck_wr_o),
		.flit_in_bypassed (flit_in_bypassed),
		.bypassed_num     (bypassed_num),
		.cyc              (cyc),
		.stb              (stb),
		.we               (we),
		.adr              (adr),
		.dat_w            (dat_w),
		.dat_r            (dat_r),
		.ack              (ack)
	);

	always #2 clk = ~clk;

	task automatic check(input string name, input wb_dat_t act, input wb_dat_t exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch %s: got 0x%08h expected 0x%08h", name, act, exp);
		end
	endtask

	function automatic void clear_model();
		for (int r = 0; r < NR; r++) begin
			for (int i = 0; i < NUM_STAT; i++) begin
				m_tot[r][i] = '0;
				for (int p = 0; p < MAX_P; p++) begin
					m_port[r][p][i] = '0;
				end
			end
		end
	endfunction

	function automatic void count_event(input int r, input int p, input int idx);
		m_port[r][p][idx] = m_port[r][p][idx] + 32'd1;
		m_tot[r][idx] = m_tot[r][idx] + 32'd1;
	endfunction

	function automatic wb_adr_t counter_adr(input int r, input int slot, input int idx);
		wb_adr_t a;
		a = '0;
		a[RTR_LSB +: RTR_W] = RTR_W'(r);
		a[SLOT_LSB +: SLOT_W] = SLOT_W'(slot);
		a[IDX_LSB +: IDX_W] = IDX_W'(idx);
		return a;
	endfunction

	// one cycle of router events and the matching model update
	task automatic drive_cycle(input logic [EV_W-1:0] fi, input logic [EV_W-1:0] pi,
			input logic [EV_W-1:0] fo, input logic [EV_W-1:0] po,
			input logic [EV_W-1:0] byp, input logic [BYP_BUS_W-1:0] bn);
		int r;
		int p;
		byp_t b;
		@(posedge clk);
		flit_wr_i <= fi;
		pck_wr_i <= pi;
		flit_wr_o <= fo;
		pck_wr_o <= po;
		flit_in_bypassed <= byp;
		bypassed_num <= bn;
		if (!m_freeze) begin
			for (int e = 0; e < EV_W; e++) begin
				r = e / MAX_P;
				p = e % MAX_P;
				b = bn[e*BYP_W +: BYP_W];
				if (fi[e]) count_event(r, p, IDX_FLIT_IN);
				if (pi[e]) count_event(r, p, IDX_PCK_IN);
				if (fo[e]) count_event(r, p, IDX_FLIT_OUT);
				if (po[e]) count_event(r, p, IDX_PCK_OUT);
				if (byp[e]) count_event(r, p, IDX_BYPASSED);
				if (fi[e] && !byp[e]) begin
					count_event(r, p, IDX_BUFFERED);
					count_event(r, p, IDX_BIN0 + int'(b));
				end
			end
		end
	endtask

	task automatic events_idle();
		@(posedge clk);
		flit_wr_i <= '0;
		pck_wr_i <= '0;
		flit_wr_o <= '0;
		pck_wr_o <= '0;
		flit_in_bypassed <= '0;
		bypassed_num <= '0;
	endtask

	task automatic port_event(input int r, input int p, input logic f_in, input logic p_in,
			input logic f_out, input logic p_out, input logic byp, input int bnum);
		logic [EV_W-1:0] fi;
		logic [EV_W-1:0] pi;
		logic [EV_W-1:0] fo;
		logic [EV_W-1:0] po;
		logic [EV_W-1:0] bv;
		logic [BYP_BUS_W-1:0] bn;
		int e;
		e = r * MAX_P + p;
		fi = '0;
		pi = '0;
		fo = '0;
		po = '0;
		bv = '0;
		bn = '0;
		fi[e] = f_in;
		pi[e] = p_in;
		fo[e] = f_out;
		po[e] = p_out;
		bv[e] = byp;
		bn[e*BYP_W +: BYP_W] = BYP_W'(bnum);
		drive_cycle(fi, pi, fo, po, bv, bn);
	endtask

	task automatic random_cycles(input int n);
		logic [EV_W-1:0] fi;
		logic [EV_W-1:0] pi;
		logic [EV_W-1:0] fo;
		logic [EV_W-1:0] po;
		logic [EV_W-1:0] bv;
		logic [BYP_BUS_W-1:0] bn;
		for (int k = 0; k < n; k++) begin
			for (int e = 0; e < EV_W; e++) begin
				fi[e] = 1'($urandom);
				pi[e] = fi[e] & 1'($urandom); // packets only with a flit
				bv[e] = fi[e] & 1'($urandom);
				fo[e] = 1'($urandom);
				po[e] = fo[e] & 1'($urandom);
				bn[e*BYP_W +: BYP_W] = BYP_W'($urandom_range(SMART_MAX));
			end
			drive_cycle(fi, pi, fo, po, bv, bn);
		end
		events_idle();
	endtask

	task automatic wait_ack(input string what, output logic got);
		int waited;
		got = 1'b0;
		waited = 0;
		while (!got && waited < ACK_TIMEOUT) begin
			@(negedge clk); // ack stable here
			if (ack) got = 1'b1;
			else waited++;
		end
		if (!got) begin
			timeouts++;
			$display("timeout: no ack within %0d cycles for %s", ACK_TIMEOUT, what);
		end
	endtask

	task automatic wb_read(input wb_adr_t a, output wb_dat_t d, output logic got);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b0;
		adr <= a;
		wait_ack($sformatf("read of 0x%03h", a), got);
		d = dat_r;
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
	endtask

	task automatic wb_write(input wb_adr_t a, input wb_dat_t d);
		logic got;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b1;
		adr <= a;
		dat_w <= d;
		wait_ack($sformatf("write of 0x%03h", a), got);
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic read_check(input string name, input wb_adr_t a, input wb_dat_t exp);
		wb_dat_t d;
		logic got;
		wb_read(a, d, got);
		if (got) check(name, d, exp);
	endtask

	// freeze and clear go through the control register
	task automatic write_ctrl(input logic frz, input logic clr);
		wb_dat_t v;
		v = '0;
		v[CTRL_FREEZE] = frz;
		v[CTRL_CLEAR] = clr;
		wb_write(CTRL_ADR, v);
		m_freeze = frz;
		if (clr) clear_model();
		repeat (2) @(posedge clk); // let the clear pulse pass
	endtask

	task automatic check_all();
		cnt_t exp;
		for (int r = 0; r < NR; r++) begin
			for (int s = 0; s < NUM_SLOT; s++) begin
				for (int i = 0; i < NUM_STAT; i++) begin
					if (s == TOTAL_SLOT) exp = m_tot[r][i];
					else exp = m_port[r][s][i];
					read_check($sformatf("dat_r r%0d slot%0d idx%0d", r, s, i),
						counter_adr(r, s, i), exp);
				end
			end
		end
	endtask

	task automatic check_total_sums();
		cnt_t sum;
		for (int r = 0; r < NR; r++) begin
			for (int i = 0; i < NUM_STAT; i++) begin
				sum = '0;
				for (int p = 0; p < MAX_P; p++) begin
					sum = sum + m_port[r][p][i];
				end
				read_check($sformatf("dat_r total r%0d idx%0d vs port sum", r, i),
					counter_adr(r, TOTAL_SLOT, i), sum);
			end
		end
	endtask

	task automatic test_after_reset();
		@(negedge clk);
		check("ack", 32'(ack), 32'd0);
		check_all();
	endtask

	task automatic test_single_port();
		port_event(0, 2, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 0); // head flit in
		repeat (3) port_event(0, 2, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
		port_event(0, 2, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 0);
		repeat (2) port_event(0, 2, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 0);
		port_event(0, 2, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 0);
		events_idle();
		check_all();
	endtask

	task automatic test_bypass_hist();
		for (int k = 0; k < 12; k++) begin
			port_event(1, 4, 1'b1, 1'b0, 1'b0, 1'b0, (k % 4) == 3, k % 3);
		end
		events_idle();
		check_all();
	endtask

	task automatic test_totals();
		random_cycles(200);
		check_all();
		check_total_sums();
	endtask

	task automatic test_freeze_clear();
		write_ctrl(1'b1, 1'b0);
		read_check("dat_r ctrl", CTRL_ADR, 32'd1);
		random_cycles(10); // dropped while frozen
		check_all();
		write_ctrl(1'b1, 1'b1); // clear beats freeze
		check_all();
		read_check("dat_r ctrl", CTRL_ADR, 32'd1);
		write_ctrl(1'b0, 1'b0);
		read_check("dat_r ctrl", CTRL_ADR, 32'd0);
		random_cycles(20);
		check_all();
	endtask

	task automatic test_address_rules();
		wb_write(counter_adr(0, 1, IDX_FLIT_IN), 32'hffff_ffff);
		read_check("dat_r after counter write", counter_adr(0, 1, IDX_FLIT_IN),
			m_port[0][1][IDX_FLIT_IN]);
		for (int i = NUM_STAT; i < 16; i++) begin
			read_check($sformatf("dat_r r0 idx%0d", i), counter_adr(0, 0, i), 32'd0);
			read_check($sformatf("dat_r r1 total idx%0d", i),
				counter_adr(1, TOTAL_SLOT, i), 32'd0);
		end
		for (int s = NUM_SLOT; s < 8; s++) begin
			read_check($sformatf("dat_r r0 slot%0d", s), counter_adr(0, s, 0), 32'd0);
			read_check($sformatf("dat_r r1 slot%0d", s), counter_adr(1, s, 3), 32'd0);
		end
		write_ctrl(1'b1, 1'b0); // freeze set so aliases of CTRL_ADR would read 1
		read_check("dat_r ctrl 0x101", 9'h101, 32'd0);
		read_check("dat_r ctrl 0x180", 9'h180, 32'd0);
		read_check("dat_r ctrl 0x1ff", 9'h1ff, 32'd0);
		write_ctrl(1'b0, 1'b0);
	endtask

	initial begin
		rst_n = 1'b0;
		flit_wr_i = '0;
		pck_wr_i = '0;
		flit_wr_o = '0;
		pck_wr_o = '0;
		flit_in_bypassed = '0;
		bypassed_num = '0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		checks = 0;
		errors = 0;
		timeouts = 0;
		m_freeze = 1'b0;
		clear_model();
		seed_ret = $urandom(32'haf4a);
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		test_after_reset();
		test_single_port();
		test_bypass_hist();
		test_totals();
		test_freeze_clear();
		test_address_rules();

		$display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/noc_stat_top.sv
// NoC router statistics unit
`timescale 1ns/1ps
`default_nettype none

module noc_stat_top (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic [noc_stat_pkg::EV_W-1:0]         flit_wr_i,
	input  logic [noc_stat_pkg::EV_W-1:0]         pck_wr_i,
	input  logic [noc_stat_pkg::EV_W-1:0]         flit_wr_o,
	input  logic [noc_stat_pkg::EV_W-1:0]         pck_wr_o,
	input  logic [noc_stat_pkg::EV_W-1:0]         flit_in_bypassed,
	input  logic [noc_stat_pkg::BYP_BUS_W-1:0]    bypassed_num,
	input  logic                                  cyc,
	input  logic                                  stb,
	input  logic                                  we,
	input  noc_stat_pkg::wb_adr_t                 adr,
	input  noc_stat_pkg::wb_dat_t                 dat_w,
	output noc_stat_pkg::wb_dat_t                 dat_r,
	output logic                                  ack
);
	import noc_stat_pkg::*;

	logic [EV_W*NUM_STAT-1:0] inc_all; // per port strobes, port-major
	logic [BUS_W-1:0] cnt_bus;
	logic freeze;
	logic clear;

	for (genvar r = 0; r < NR; r++) begin : g_rtr
		for (genvar p = 0; p < MAX_P; p++) begin : g_port
			port_event_counter u_port (
				.clk              (clk),
				.rst_n            (rst_n),
				.flit_wr_i        (flit_wr_i[r*MAX_P + p]),
				.pck_wr_i         (pck_wr_i[r*MAX_P + p]),
				.flit_wr_o        (flit_wr_o[r*MAX_P + p]),
				.pck_wr_o         (pck_wr_o[r*MAX_P + p]),
				.flit_in_bypassed (flit_in_bypassed[r*MAX_P + p]),
				.bypassed_num     (bypassed_num[(r*MAX_P + p)*BYP_W +: BYP_W]),
				.freeze           (freeze),
				.clear            (clear),
				.inc              (inc_all[(r*MAX_P + p)*NUM_STAT +: NUM_STAT]),
				.cnt              (cnt_bus[(r*NUM_SLOT + p)*SET_W +: SET_W])
			);
		end

		router_stat_total u_total (
			.clk      (clk),
			.rst_n    (rst_n),
			.port_inc (inc_all[r*MAX_P*NUM_STAT +: MAX_P*NUM_STAT]),
			.freeze   (freeze),
			.clear    (clear),
			.cnt      (cnt_bus[(r*NUM_SLOT + TOTAL_SLOT)*SET_W +: SET_W]) // total slot
		);
	end

	stat_wb_slave u_wb_slave (
		.clk     (clk),
		.rst_n   (rst_n),
		.cyc     (cyc),
		.stb     (stb),
		.we      (we),
		.adr     (adr),
		.dat_w   (dat_w),
		.dat_r   (dat_r),
		.ack     (ack),
		.cnt_bus (cnt_bus),
		.freeze  (freeze),
		.clear   (clear)
	);

endmodule

`default_nettype wire

//--- logic/stat_wb_slave.sv
// Statistics Wishbone read-out slave
`timescale 1ns/1ps
`default_nettype none

module stat_wb_slave (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               cyc,
	input  logic                               stb,
	input  logic                               we,
	input  noc_stat_pkg::wb_adr_t              adr,
	input  noc_stat_pkg::wb_dat_t              dat_w,
	output noc_stat_pkg::wb_dat_t              dat_r,
	output logic                               ack,
	input  logic [noc_stat_pkg::BUS_W-1:0]     cnt_bus,
	output logic                               freeze,
	output logic                               clear
);
	import noc_stat_pkg::*;

	logic [RTR_W-1:0] rtr;
	logic [SLOT_W-1:0] slot;
	logic [IDX_W-1:0] idx;
	logic ctrl_sel;
	logic ctrl_hit;
	logic cnt_hit;
	logic [WSEL_W-1:0] word_sel;
	cnt_t cnt_word [NUM_WORDS];
	wb_dat_t rd_word;
	logic req;
	logic done;
	logic ack_q;
	logic freeze_q;
	logic clr_arm;
	logic clear_q;

	// address fields
	assign idx = adr[IDX_LSB +: IDX_W];
	assign slot = adr[SLOT_LSB +: SLOT_W];
	assign rtr = adr[RTR_LSB +: RTR_W];
	assign ctrl_sel = adr[CTRL_SEL];
	assign ctrl_hit = (adr == CTRL_ADR);
	assign cnt_hit = !ctrl_sel && (int'(slot) < NUM_SLOT) && (int'(idx) < NUM_STAT);

	// word number within the flattened counter bus
	assign word_sel = WSEL_W'((int'(rtr) * NUM_SLOT + int'(slot)) * NUM_STAT + int'(idx));

	for (genvar w = 0; w < NUM_WORDS; w++) begin : g_word
		assign cnt_word[w] = cnt_bus[w*CNT_W +: CNT_W];
	end

	always_comb begin
		rd_word = '0;
		if (ctrl_sel) begin
			if (ctrl_hit) begin
				rd_word[CTRL_FREEZE] = freeze_q;
			end
		end else if (cnt_hit) begin
			rd_word = cnt_word[word_sel];
		end
	end

	// new request only once stb has dropped after the last ack
	assign req = cyc && stb && !done;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			done <= 1'b0;
		end else if (req) begin
			ack_q <= 1'b1;
			done <= 1'b1;
		end else begin
			ack_q <= 1'b0;
			if (!stb) begin
				done <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			dat_r <= we ? '0 : rd_word;
		end
	end

	// control register and clear pulse one cycle after the ack
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			freeze_q <= 1'b0;
			clr_arm <= 1'b0;
			clear_q <= 1'b0;
		end else begin
			clr_arm <= req && we && ctrl_hit && dat_w[CTRL_CLEAR];
			clear_q <= clr_arm;
			if (req && we && ctrl_hit) begin
				freeze_q <= dat_w[CTRL_FREEZE];
			end
		end
	end

	assign ack = ack_q;
	assign freeze = freeze_q;
	assign clear = clear_q;

	a_ack_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		ack_q |=> !ack_q
	) else $error("ack high for two cycles");

	a_ack_needs_cyc: assert property (
		@(posedge clk) disable iff (!rst_n)
		ack_q |-> $past(cyc)
	) else $error("ack without cyc on the previous edge");

endmodule

`default_nettype wire

//--- logic/router_stat_total.sv
// Router total event counters
`timescale 1ns/1ps
`default_nettype none

module router_stat_total (
	input  logic                                           clk,
	input  logic                                           rst_n,
	input  logic [noc_stat_pkg::MAX_P*noc_stat_pkg::NUM_STAT-1:0] port_inc,
	input  logic                                           freeze,
	input  logic                                           clear,
	output logic [noc_stat_pkg::SET_W-1:0]                 cnt
);
	import noc_stat_pkg::*;

	logic [INC_W-1:0] inc_sum [NUM_STAT];
	cnt_t tot_q [NUM_STAT];

	// population count of each strobe across the ports
	always_comb begin
		for (int i = 0; i < NUM_STAT; i++) begin
			inc_sum[i] = '0;
			for (int p = 0; p < MAX_P; p++) begin
				inc_sum[i] = inc_sum[i] + INC_W'(port_inc[p*NUM_STAT + i]);
			end
		end
	end

	// same clear and freeze as the port counters so the sums stay equal
	for (genvar i = 0; i < NUM_STAT; i++) begin : g_tot
		always_ff @(posedge clk) begin
			if (!rst_n || clear) begin
				tot_q[i] <= '0;
			end else if (!freeze) begin
				tot_q[i] <= tot_q[i] + CNT_W'(inc_sum[i]);
			end
		end

		assign cnt[i*CNT_W +: CNT_W] = tot_q[i];
	end

endmodule

`default_nettype wire

//--- logic/port_event_counter.sv
// Router port event counters
`timescale 1ns/1ps
`default_nettype none

module port_event_counter (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                flit_wr_i,
	input  logic                                pck_wr_i,
	input  logic                                flit_wr_o,
	input  logic                                pck_wr_o,
	input  logic                                flit_in_bypassed,
	input  noc_stat_pkg::byp_t                  bypassed_num,
	input  logic                                freeze,
	input  logic                                clear,
	output noc_stat_pkg::stat_vec_t             inc,
	output logic [noc_stat_pkg::SET_W-1:0]      cnt
);
	import noc_stat_pkg::*;

	logic buffered;
	cnt_t cnt_q [NUM_STAT];

	// a flit that was written in but did not take the bypass path
	assign buffered = flit_wr_i && !flit_in_bypassed;

	always_comb begin
		inc = '0;
		inc[IDX_FLIT_IN] = flit_wr_i;
		inc[IDX_PCK_IN] = pck_wr_i;
		inc[IDX_FLIT_OUT] = flit_wr_o;
		inc[IDX_PCK_OUT] = pck_wr_o;
		inc[IDX_BUFFERED] = buffered;
		inc[IDX_BYPASSED] = flit_in_bypassed;
		for (int b = 0; b < NUM_BINS; b++) begin
			inc[IDX_BIN0 + b] = buffered && (bypassed_num == BYP_W'(b)); // one-hot bin
		end
	end

	for (genvar i = 0; i < NUM_STAT; i++) begin : g_cnt
		always_ff @(posedge clk) begin
			if (!rst_n || clear) begin
				cnt_q[i] <= '0;
			end else if (!freeze && inc[i]) begin
				cnt_q[i] <= cnt_q[i] + 1'b1; // wraps at 2^32
			end
		end

		assign cnt[i*CNT_W +: CNT_W] = cnt_q[i];
	end

	// router side guarantees on the event strobes
	a_pck_in_has_flit: assert property (
		@(posedge clk) disable iff (!rst_n)
		pck_wr_i |-> flit_wr_i
	) else $error("pck_wr_i without flit_wr_i");

	a_bypass_has_flit: assert property (
		@(posedge clk) disable iff (!rst_n)
		flit_in_bypassed |-> flit_wr_i
	) else $error("flit_in_bypassed without flit_wr_i");

	// a bypass count above SMART_MAX would have no bin to land in
	a_bin_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		buffered |-> (int'(bypassed_num) <= SMART_MAX)
	) else $error("bypassed_num %0d above SMART_MAX", bypassed_num);

endmodule

`default_nettype wire

//--- logic/noc_stat_pkg.sv
// NoC router statistics definitions
`default_nettype none

package noc_stat_pkg;

	// network size
	localparam int NR = 2;
	localparam int MAX_P = 5;
	localparam int SMART_MAX = 2;
	localparam int NUM_BINS = SMART_MAX + 1;
	localparam int BYP_W = 2;

	// counter set
	localparam int NUM_STAT = 6 + NUM_BINS;
	localparam int CNT_W = 32;
	localparam int IDX_FLIT_IN = 0;
	localparam int IDX_PCK_IN = 1;
	localparam int IDX_FLIT_OUT = 2;
	localparam int IDX_PCK_OUT = 3;
	localparam int IDX_BUFFERED = 4;
	localparam int IDX_BYPASSED = 5;
	localparam int IDX_BIN0 = 6; // bin n at IDX_BIN0 + n

	// derived widths for flattened buses
	localparam int INC_W = $clog2(MAX_P + 1); // 0..MAX_P strobes per cycle
	localparam int EV_W = NR * MAX_P;
	localparam int BYP_BUS_W = EV_W * BYP_W;
	localparam int NUM_SLOT = MAX_P + 1; // ports plus total
	localparam int SET_W = NUM_STAT * CNT_W;
	localparam int BUS_W = NR * NUM_SLOT * SET_W;
	localparam int NUM_WORDS = NR * NUM_SLOT * NUM_STAT;
	localparam int WSEL_W = $clog2(NUM_WORDS);

	typedef logic [CNT_W-1:0] cnt_t;
	typedef logic [NUM_STAT-1:0] stat_vec_t;
	typedef logic [BYP_W-1:0] byp_t;

	// Wishbone address map
	localparam int ADR_W = 9;
	localparam int DAT_W = 32;
	localparam int IDX_LSB = 0;
	localparam int IDX_W = 4;
	localparam int SLOT_LSB = 4;
	localparam int SLOT_W = 3;
	localparam int RTR_LSB = 7;
	localparam int RTR_W = 1;
	localparam int CTRL_SEL = 8;
	localparam int TOTAL_SLOT = MAX_P;

	typedef logic [ADR_W-1:0] wb_adr_t;
	typedef logic [DAT_W-1:0] wb_dat_t;

	localparam wb_adr_t CTRL_ADR = 9'h100;
	localparam int CTRL_FREEZE = 0;
	localparam int CTRL_CLEAR = 1;

endpackage

`default_nettype wire
